// ==== filelist.f ====
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/branch_resolve.sv
verilog/eflags_reg.sv
verilog/pipestage.sv
verilog/execute_top.sv
verif/tb_execute_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator, run it, and look for the pass line
verilator --binary --timing --assert -f filelist.f --top-module tb_execute_top &&
    ./obj_dir/Vtb_execute_top | tee /dev/stderr | grep -qx "No errors" &&
    echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }

// ==== verif/tb_execute_top.sv ====
//************************************************************
// Execute stage testbench
// Random requests checked against a reference model, with
// writeback stalls and flushes
//************************************************************

module tb_execute_top;
    import exec_pkg::*;

    localparam int NUM_REQ    = 400;
    localparam int MAX_CYCLES = 3000;

    logic      clk;
    logic      arst_n;
    logic      flush;
    logic      e_valid;
    logic      e_ready;
    exec_req_t e_req;
    logic      wb_ready;
    logic      wb_valid;
    wb_res_t   wb_res;
    eflags_t   eflags;

    integer    seed = 32'h1983_b806;
    int        cycles = 0;
    int        accepted = 0;
    int        compared = 0;
    int        dropped = 0;
    eflags_t   model_flags = '0;
    logic      stalled = 1'b0;
    wb_res_t   held_res;
    wb_res_t   exp_q[$];
    int        idx_q[$];

    execute_top execute_top_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .e_valid  (e_valid),
        .e_ready  (e_ready),
        .e_req    (e_req),
        .wb_ready (wb_ready),
        .wb_valid (wb_valid),
        .wb_res   (wb_res),
        .eflags   (eflags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string phase_of(input int n);
        if (n < 100) begin
            return "arith";
        end else if (n < 160) begin
            return "logic";
        end else if (n < 280) begin
            return "branch";
        end
        return "mixed";
    endfunction

    // Codes come in pairs, the odd one negates the base test
    function automatic logic cond_holds(input cond_e cc, input eflags_t fl);
        logic [3:0] code;
        logic       base;
        code = cc;
        case (code[3:1])
            3'd0:    base = fl.of;
            3'd1:    base = fl.cf;
            3'd2:    base = fl.zf;
            3'd3:    base = fl.cf | fl.zf;
            3'd4:    base = fl.sf;
            3'd5:    base = fl.pf;
            3'd6:    base = fl.sf ^ fl.of;
            default: base = fl.zf | (fl.sf ^ fl.of);
        endcase
        return base ^ code[0];
    endfunction

    // Expected writeback record and flags after one instruction
    function automatic wb_res_t ref_exec(input exec_req_t req, input eflags_t fl,
                                         output eflags_t nfl);
        wb_res_t     res;
        logic [31:0] mask;
        logic [31:0] topbit;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [32:0] full;
        logic        c;
        logic        sa;
        logic        sb;
        logic        sr;
        logic        taken;
        case (req.opsize)
            SZ8:     mask = 32'h0000_00ff;
            SZ16:    mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
        topbit = mask ^ (mask >> 1);
        a = req.op_a & mask;
        b = req.op_b & mask;
        sa = (a & topbit) != 32'd0;
        sb = (b & topbit) != 32'd0;
        nfl = fl;
        case (req.op)
            ADD, ADC: begin
                c = (req.op == ADC) & fl.cf;
                full = {1'b0, a} + {1'b0, b} + {32'd0, c};
                r = full[31:0] & mask;
                nfl.cf = (full & {1'b1, ~mask}) != 33'd0;
                nfl.af = ({1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, c}) > 5'd15;
            end
            SUB, SBB, CMP: begin
                c = (req.op == SBB) & fl.cf;
                full = {1'b0, a} - {1'b0, b} - {32'd0, c};
                r = full[31:0] & mask;
                nfl.cf = {1'b0, a} < ({1'b0, b} + {32'd0, c});
                nfl.af = {1'b0, a[3:0]} < ({1'b0, b[3:0]} + {4'd0, c});
            end
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            MOV:     r = b;
            default: r = 32'd0;
        endcase
        sr = (r & topbit) != 32'd0;
        if (req.op inside {ADD, ADC}) begin
            nfl.of = (sa == sb) && (sr != sa);
        end else if (req.op inside {SUB, SBB, CMP}) begin
            nfl.of = (sa != sb) && (sr != sa);
        end else if (req.op inside {AND, OR, XOR}) begin
            nfl.cf = 1'b0;
            nfl.of = 1'b0;
            nfl.af = 1'b0;
        end
        if (req.op inside {ADD, ADC, SUB, SBB, CMP, AND, OR, XOR}) begin
            nfl.zf = (r == 32'd0);
            nfl.sf = sr;
            nfl.pf = ~^r[7:0];
        end
        if (req.set_df) begin
            nfl.df = 1'b1;
        end else if (req.clear_df) begin
            nfl.df = 1'b0;
        end
        taken = (req.op == JMP) || ((req.op == JCC) && cond_holds(req.cond, fl));
        res.dest_reg      = req.dest_reg;
        res.result        = r;
        res.opsize        = req.opsize;
        res.write_reg     = !(req.op inside {CMP, JCC, JMP, NOP});
        res.pc            = req.pc;
        res.br_taken      = taken;
        res.br_mispredict = (req.op inside {JCC, JMP}) && (taken != req.pred_taken);
        res.jump_address  = taken ? req.op_b : req.next_pc;
        return res;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_res(input string name, input wb_res_t exp, input wb_res_t got);
        assert (got == exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, got);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_flags(input string name, input eflags_t exp, input eflags_t got);
        assert (got == exp) else begin
            $display("[FAIL] %s expected %h actual %h", name, exp, got);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        assert (got == exp) else begin
            $display("[FAIL] %s expected %b actual %b", name, exp, got);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Edge values now and then to hit carries and overflows
    task automatic pick_operand(output logic [31:0] v);
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    v = 32'h0000_0000;
            3'd1:    v = 32'hffff_ffff;
            3'd2:    v = 32'h8000_8080;
            3'd3:    v = 32'h7fff_7f7f;
            default: v = $random(seed);
        endcase
    endtask

    task automatic gen_req(input int n, output exec_req_t req);
        logic [31:0] r;
        logic [3:0]  k;
        r = $random(seed);
        k = r[23:20];
        req.dest_reg   = r[2:0];
        req.pred_taken = r[3];
        req.set_df     = (r[6:4] == 3'd0);
        req.clear_df   = (r[9:7] == 3'd0);
        case (r[11:10])
            2'd0:    req.opsize = SZ8;
            2'd1:    req.opsize = SZ16;
            default: req.opsize = SZ32;
        endcase
        req.cond = cond_e'(r[15:12]);
        pick_operand(req.op_a);
        pick_operand(req.op_b);
        req.pc      = $random(seed);
        req.next_pc = req.pc + {28'd0, r[19:16]} + 32'd1;
        if (n < 100) begin
            req.op = alu_op_e'(k % 4'd5);
        end else if (n < 160) begin
            req.op = alu_op_e'(4'd5 + {2'd0, k[1:0]});
        end else if (n < 280) begin
            // Arithmetic mixed in so the conditions see fresh flags
            if (k[3]) begin
                req.op = alu_op_e'(k % 4'd5);
            end else if (k[1:0] == 2'd0) begin
                req.op = JMP;
            end else begin
                req.op = JCC;
            end
        end else begin
            req.op = alu_op_e'(k % 4'd12);
        end
    endtask

    task automatic drive_sink();
        logic [31:0] r;
        r = $random(seed);
        wb_ready <= (r[1:0] != 2'd0);
        flush    <= (r[7:4] == 4'd0);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            stop_run($sformatf("Run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // Reference model and comparison
    always @(posedge clk) begin
        wb_res_t exp;
        eflags_t nfl;
        int      idx;
        logic    occupied;
        if (arst_n) begin
            // The model queue holds exactly the result in the pipestage
            occupied = (exp_q.size() != 0);
            check_bit("wb_valid", occupied, wb_valid);
            check_bit("e_ready", (!occupied || wb_ready) && !flush, e_ready);
            if (stalled) begin
                check_res("stall hold", held_res, wb_res);
            end
            if (flush && wb_valid) begin
                assert (exp_q.size() != 0) else stop_run("Flushed a result never accepted");
                void'(exp_q.pop_front());
                void'(idx_q.pop_front());
                dropped++;
            end else if (wb_valid && wb_ready) begin
                assert (exp_q.size() != 0) else stop_run("Writeback with no result expected");
                exp = exp_q.pop_front();
                idx = idx_q.pop_front();
                check_res($sformatf("%s record %0d", phase_of(idx), idx), exp, wb_res);
                compared++;
            end
            check_flags("eflags", model_flags, eflags);
            stalled  = wb_valid && !wb_ready && !flush;
            held_res = wb_res;
            if (e_valid && e_ready) begin
                exp = ref_exec(e_req, model_flags, nfl);
                exp_q.push_back(exp);
                idx_q.push_back(accepted);
                accepted++;
                model_flags = nfl;
            end
        end
    end

    initial begin
        exec_req_t req;
        int        sent;
        e_valid  <= 1'b0;
        e_req    <= '0;
        wb_ready <= 1'b0;
        flush    <= 1'b0;
        arst_n   <= 1'b0;
        sent = 0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        gen_req(0, req);
        e_req   <= req;
        e_valid <= 1'b1;
        drive_sink();
        while (sent < NUM_REQ) begin
            @(posedge clk);
            if (e_valid && e_ready) begin
                sent++;
            end
            drive_sink();
            // Valid holds until accepted, then maybe a bubble
            if (!(e_valid && !e_ready)) begin
                if (sent < NUM_REQ && ($random(seed) & 7) != 0) begin
                    gen_req(sent, req);
                    e_req   <= req;
                    e_valid <= 1'b1;
                end else begin
                    e_valid <= 1'b0;
                end
            end
        end
        @(negedge clk);
        while (compared + dropped < NUM_REQ) begin
            @(posedge clk);
            drive_sink();
            @(negedge clk);
        end
        if (exp_q.size() == 0 && accepted == NUM_REQ && compared + dropped == NUM_REQ &&
            !wb_valid) begin
            $display("No errors");
            $finish;
        end else begin
            stop_run($sformatf("Run ended with %0d accepted, %0d results left over, valid %b",
                               accepted, exp_q.size(), wb_valid));
        end
    end

endmodule

// ==== verilog/branch_resolve.sv ====
//**********************************************************
// Branch resolver
// Condition check, redirect address and misprediction
//**********************************************************

module branch_resolve (
    input  exec_pkg::exec_req_t req,
    input  exec_pkg::eflags_t   flags,
    output logic                taken,
    output logic [31:0]         jump_address,
    output logic                mispredict
);
    import exec_pkg::*;

    logic cond_true;
    logic is_jump;

    // Flags as they stood before this instruction
    always_comb begin
        case (req.cond)
            CC_O:    cond_true = flags.of;
            CC_NO:   cond_true = ~flags.of;
            CC_B:    cond_true = flags.cf;
            CC_AE:   cond_true = ~flags.cf;
            CC_E:    cond_true = flags.zf;
            CC_NE:   cond_true = ~flags.zf;
            CC_BE:   cond_true = flags.cf | flags.zf;
            CC_A:    cond_true = ~(flags.cf | flags.zf);
            CC_S:    cond_true = flags.sf;
            CC_NS:   cond_true = ~flags.sf;
            CC_P:    cond_true = flags.pf;
            CC_NP:   cond_true = ~flags.pf;
            // Signed compares use SF against OF
            CC_L:    cond_true = flags.sf ^ flags.of;
            CC_GE:   cond_true = ~(flags.sf ^ flags.of);
            CC_LE:   cond_true = flags.zf | (flags.sf ^ flags.of);
            default: cond_true = ~(flags.zf | (flags.sf ^ flags.of));
        endcase
    end

    assign is_jump = (req.op == JCC) || (req.op == JMP);

    assign taken = (req.op == JMP) || ((req.op == JCC) && cond_true);

    // Fall-through when not taken
    assign jump_address = taken ? req.op_b : req.next_pc;

    assign mispredict = is_jump && (taken != req.pred_taken);

endmodule

// ==== verilog/eflags_reg.sv ====
//**********************************************************
// EFLAGS register
// Per-flag masked writes plus direction flag strobes
//**********************************************************

module eflags_reg (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              upd_en,
    input  logic [5:0]        flag_val,
    input  logic [5:0]        flag_upd,
    input  logic              set_df,
    input  logic              clear_df,
    output exec_pkg::eflags_t eflags
);

    logic [5:0] wr_mask;

    assign wr_mask = flag_upd & {6{upd_en}};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eflags <= '0;
        end else begin
            // Arithmetic flags only where the mask allows
            eflags[5:0] <= (eflags[5:0] & ~wr_mask) | (flag_val & wr_mask);
            // Set wins over clear
            if (upd_en && set_df) begin
                eflags.df <= 1'b1;
            end else if (upd_en && clear_df) begin
                eflags.df <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/exec_alu.sv ====
//**********************************************************
// Execute stage ALU
// Add/subtract and logic at 8, 16 or 32 bits with flags
//**********************************************************

module exec_alu (
    input  exec_pkg::exec_req_t req,
    input  exec_pkg::eflags_t   flags,
    output logic [31:0]         result,
    output logic [5:0]          flag_val,
    output logic [5:0]          flag_upd
);
    import exec_pkg::*;

    logic [31:0] size_mask;
    logic [31:0] a_s;
    logic [31:0] b_s;
    logic [31:0] b_eff;
    logic [32:0] sum;
    logic        is_arith;
    logic        is_sub;
    logic        is_logic;
    logic        cin;
    logic        carry_out;
    logic        a_msb;
    logic        b_msb;
    logic        r_msb;
    logic        cf;
    logic        of;
    logic        af;
    logic        zf;
    logic        sf;
    logic        pf;

    always_comb begin
        case (req.opsize)
            SZ8:     size_mask = 32'h0000_00ff;
            SZ16:    size_mask = 32'h0000_ffff;
            default: size_mask = 32'hffff_ffff;
        endcase
    end

    assign a_s = req.op_a & size_mask;
    assign b_s = req.op_b & size_mask;

    assign is_arith = req.op inside {ADD, ADC, SUB, SBB, CMP};
    assign is_sub   = req.op inside {SUB, SBB, CMP};
    assign is_logic = req.op inside {AND, OR, XOR};

    // Subtract as a + ~b + 1, borrow folds into the carry-in
    assign b_eff = (is_sub ? ~b_s : b_s) & size_mask;

    always_comb begin
        case (req.op)
            ADC:          cin = flags.cf;
            SUB, CMP:     cin = 1'b1;
            SBB:          cin = ~flags.cf;
            default:      cin = 1'b0;
        endcase
    end

    assign sum = {1'b0, a_s} + {1'b0, b_eff} + {32'd0, cin};

    always_comb begin
        case (req.op)
            ADD, ADC, SUB, SBB, CMP: result = sum[31:0] & size_mask;
            AND:                     result = a_s & b_s;
            OR:                      result = a_s | b_s;
            XOR:                     result = a_s ^ b_s;
            MOV:                     result = b_s;
            // Jumps and NOP write nothing back
            default:                 result = 32'd0;
        endcase
    end

    // Sign bits and carry out at the selected size
    always_comb begin
        case (req.opsize)
            SZ8: begin
                a_msb     = a_s[7];
                b_msb     = b_eff[7];
                r_msb     = result[7];
                carry_out = sum[8];
            end
            SZ16: begin
                a_msb     = a_s[15];
                b_msb     = b_eff[15];
                r_msb     = result[15];
                carry_out = sum[16];
            end
            default: begin
                a_msb     = a_s[31];
                b_msb     = b_eff[31];
                r_msb     = result[31];
                carry_out = sum[32];
            end
        endcase
    end

    // Borrow is the inverted carry on the subtract path
    assign cf = is_arith & (carry_out ^ is_sub);
    assign of = is_arith & (a_msb ~^ b_msb) & (a_msb ^ r_msb);
    assign af = is_arith & (a_s[4] ^ b_s[4] ^ result[4]);
    assign zf = (result == 32'd0);
    assign sf = r_msb;
    assign pf = ~^result[7:0];

    assign flag_val = {of, sf, zf, af, pf, cf};
    assign flag_upd = (is_arith | is_logic) ? 6'h3f : 6'h00;

endmodule

// ==== verilog/exec_pkg.sv ====
//**********************************************************
// Execute stage shared types
// Operation, condition and size encodings, flags and records
//**********************************************************

package exec_pkg;

    // Operation class from decode
    typedef enum logic [3:0] {
        ADD = 4'd0,
        ADC,
        SUB,
        SBB,
        CMP,
        AND,
        OR,
        XOR,
        MOV,
        JCC,
        JMP,
        NOP
    } alu_op_e;

    // x86 condition codes in tttn order
    typedef enum logic [3:0] {
        CC_O  = 4'h0,
        CC_NO,
        CC_B,
        CC_AE,
        CC_E,
        CC_NE,
        CC_BE,
        CC_A,
        CC_S,
        CC_NS,
        CC_P,
        CC_NP,
        CC_L,
        CC_GE,
        CC_LE,
        CC_G
    } cond_e;

    typedef enum logic [1:0] {
        SZ8  = 2'd0,
        SZ16 = 2'd1,
        SZ32 = 2'd2
    } opsize_e;

    // Low six bits line up with the ALU flag vector
    typedef struct packed {
        logic df;
        logic of;
        logic sf;
        logic zf;
        logic af;
        logic pf;
        logic cf;
    } eflags_t;

    typedef struct packed {
        alu_op_e     op;
        cond_e       cond;
        opsize_e     opsize;
        logic [2:0]  dest_reg;
        logic [31:0] op_a;
        logic [31:0] op_b;     // jump target for JCC/JMP
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic        pred_taken;
        logic        set_df;
        logic        clear_df;
    } exec_req_t;

    typedef struct packed {
        logic [2:0]  dest_reg;
        logic [31:0] result;
        opsize_e     opsize;
        logic        write_reg;
        logic [31:0] pc;
        logic        br_taken;
        logic        br_mispredict;
        logic [31:0] jump_address;
    } wb_res_t;

endpackage

// ==== verilog/execute_top.sv ====
//**********************************************************
// Execute stage top
// ALU, branch resolver, EFLAGS and writeback pipestage
//**********************************************************

module execute_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                e_valid,
    output logic                e_ready,
    input  exec_pkg::exec_req_t e_req,
    input  logic                wb_ready,
    output logic                wb_valid,
    output exec_pkg::wb_res_t   wb_res,
    output exec_pkg::eflags_t   eflags
);
    import exec_pkg::*;

    logic [31:0] alu_result;
    logic [5:0]  alu_flag_val;
    logic [5:0]  alu_flag_upd;
    logic        br_taken;
    logic [31:0] br_jump_address;
    logic        br_mispredict;
    logic        accept;
    logic        write_reg;
    wb_res_t     stage_in;

    exec_alu exec_alu_inst (
        .req      (e_req),
        .flags    (eflags),
        .result   (alu_result),
        .flag_val (alu_flag_val),
        .flag_upd (alu_flag_upd)
    );

    branch_resolve branch_resolve_inst (
        .req          (e_req),
        .flags        (eflags),
        .taken        (br_taken),
        .jump_address (br_jump_address),
        .mispredict   (br_mispredict)
    );

    // Flags commit on the same edge the request is taken
    assign accept = e_valid & e_ready;

    eflags_reg eflags_reg_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .upd_en   (accept),
        .flag_val (alu_flag_val),
        .flag_upd (alu_flag_upd),
        .set_df   (e_req.set_df),
        .clear_df (e_req.clear_df),
        .eflags   (eflags)
    );

    // Compares, jumps and NOP leave the register file alone
    assign write_reg = !(e_req.op inside {CMP, JCC, JMP, NOP});

    always_comb begin
        stage_in.dest_reg      = e_req.dest_reg;
        stage_in.result        = alu_result;
        stage_in.opsize        = e_req.opsize;
        stage_in.write_reg     = write_reg;
        stage_in.pc            = e_req.pc;
        stage_in.br_taken      = br_taken;
        stage_in.br_mispredict = br_mispredict;
        stage_in.jump_address  = br_jump_address;
    end

    pipestage pipestage_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (e_valid),
        .in_ready  (e_ready),
        .in_data   (stage_in),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (wb_res)
    );

endmodule

// ==== verilog/pipestage.sv ====
//**********************************************************
// Writeback pipestage
// One-entry holding register with valid/ready and flush
//**********************************************************

module pipestage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              in_valid,
    output logic              in_ready,
    input  exec_pkg::wb_res_t in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output exec_pkg::wb_res_t out_data
);

    // Empty, or draining this cycle, and not flushing
    assign in_ready = (~out_valid | out_ready) & ~flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule
